/* cache_ctrl_pe.sv */
// Control of the three-stage cache pipeline.
// One request in flight per stage, and stage 2 only ever holds a load miss.
// Refill must not arrive before the cycle after miss_req_o.
module cache_ctrl_pe (
    input  logic clk_i,
    input  logic rst_ni,

    input  logic core_req_valid_i,
    input  logic st1_is_store_i,
    input  logic st1_is_load_i,
    input  logic dir_hit_i,
    input  logic refill_valid_i,

    output logic core_req_ready_o,
    output logic array_read_o,
    output logic st1_load_o,
    output logic st2_load_o,
    output logic data_write_o,
    output logic refill_write_o,
    output logic rsp_valid_o,
    output logic rsp_from_refill_o,
    output logic mem_write_o,
    output logic miss_req_o
);

    logic st1_valid_q;
    logic st2_pend_q;
    logic st2_first_q;
    logic st1_hit;
    logic st1_store;
    logic st1_miss;
    logic accept;

    assign st1_hit   = st1_valid_q & dir_hit_i;
    assign st1_store = st1_valid_q & st1_is_store_i;
    assign st1_miss  = st1_valid_q & st1_is_load_i & ~dir_hit_i;

    // Store gives a one-cycle bubble, a miss blocks until its refill is taken
    assign core_req_ready_o = ~st1_store & ~st1_miss & ~st2_pend_q;

    assign accept       = core_req_valid_i & core_req_ready_o;
    assign array_read_o = accept;
    assign st1_load_o   = accept;

    // Stores are write-through, the array is only touched on a hit
    assign mem_write_o  = st1_store;
    assign data_write_o = st1_store & dir_hit_i;

    assign st2_load_o = st1_miss;
    assign miss_req_o = st2_first_q;

    assign refill_write_o    = st2_pend_q & refill_valid_i;
    assign rsp_from_refill_o = refill_write_o;
    assign rsp_valid_o       = (st1_hit & st1_is_load_i) | refill_write_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            st1_valid_q <= 1'b0;
            st2_pend_q  <= 1'b0;
            st2_first_q <= 1'b0;
        end else begin
            st1_valid_q <= accept;
            st2_first_q <= st2_load_o;
            if (st2_load_o) begin
                st2_pend_q <= 1'b1;
            end else if (refill_write_o) begin
                st2_pend_q <= 1'b0;
            end
        end
    end

endmodule

/* cache_data.sv */
// Data array of the cache, one word per way read at stage 0.
// Store hits write bytes of one word, a refill writes a whole line.
// Both write ports never fire in the same cycle.
module cache_data
    import cache_pkg::*;
(
    input  logic              clk_i,

    input  logic              read_i,
    input  logic [SET_W-1:0]  read_set_i,
    input  logic [WORD_W-1:0] read_word_i,

    input  logic              write_i,
    input  logic [SET_W-1:0]  write_set_i,
    input  logic [WORD_W-1:0] write_word_i,
    input  logic              write_way_i,
    input  logic [DATA_W-1:0] write_data_i,
    input  logic [BE_W-1:0]   write_be_i,

    input  logic              refill_i,
    input  logic [SET_W-1:0]  refill_set_i,
    input  logic              refill_way_i,
    input  logic [LINE_W-1:0] refill_data_i,

    output logic [DATA_W-1:0] rdata_o
);

    logic [DATA_W-1:0] data_mem [NUM_WAYS][NUM_SETS][LINE_WORDS];
    logic [DATA_W-1:0] rd_word_q [NUM_WAYS];

    always_ff @(posedge clk_i) begin
        if (read_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_word_q[w] <= data_mem[w][read_set_i][read_word_i];
            end
        end
        if (write_i) begin
            for (int b = 0; b < BE_W; b++) begin
                if (write_be_i[b]) begin
                    data_mem[write_way_i][write_set_i][write_word_i][b*BYTE_W +: BYTE_W]
                        <= write_data_i[b*BYTE_W +: BYTE_W];
                end
            end
        end
        if (refill_i) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                data_mem[refill_way_i][refill_set_i][i] <= line_word(refill_data_i, WORD_W'(i));
            end
        end
    end

    // Hit way from the directory picks among the words read
    assign rdata_o = rd_word_q[write_way_i];

endmodule

/* cache_dir.sv */
// Cache directory: tags, valid bits and one LRU bit per set.
// Two ways only, the way index is one bit. The LRU bit names the way to
// replace next. Tags and valid bits are read at stage 0 and compared in stage 1.
module cache_dir
    import cache_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_ni,

    input  logic             read_i,
    input  logic [SET_W-1:0] read_set_i,
    input  logic [TAG_W-1:0] st1_tag_i,

    input  logic             refill_i,
    input  req_addr_u        refill_addr_i,

    output logic             hit_o,
    output logic             hit_way_o,
    output logic             victim_way_o
);

    logic [TAG_W-1:0]    tag_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
    logic [NUM_SETS-1:0] lru_q;
    logic [TAG_W-1:0]    rd_tag_q [NUM_WAYS];
    logic [NUM_WAYS-1:0] rd_valid_q;
    logic                read_q;
    logic [SET_W-1:0]    read_set_q;
    logic [NUM_WAYS-1:0] match;
    logic [SET_W-1:0]    refill_set;

    assign refill_set = refill_addr_i.c.set;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = rd_valid_q[w] & (rd_tag_q[w] == st1_tag_i);
        end
    end

    assign hit_o        = read_q & (|match);
    assign hit_way_o    = match[1];
    assign victim_way_o = lru_q[refill_set];

    always_ff @(posedge clk_i) begin
        if (read_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_tag_q[w]   <= tag_mem[w][read_set_i];
                rd_valid_q[w] <= valid_q[w][read_set_i];
            end
        end
        if (refill_i) begin
            tag_mem[victim_way_o][refill_set] <= refill_addr_i.c.tag;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '{default: '0};
            lru_q      <= '0;
            read_q     <= 1'b0;
            read_set_q <= '0;
        end else begin
            read_q <= read_i;
            if (read_i) begin
                read_set_q <= read_set_i;
            end
            // Point away from the way just used
            if (hit_o) begin
                lru_q[read_set_q] <= ~hit_way_o;
            end
            if (refill_i) begin
                valid_q[victim_way_o][refill_set] <= 1'b1;
                lru_q[refill_set]                 <= ~victim_way_o;
            end
        end
    end

endmodule

/* cache_pkg.sv */
// Shared sizes and address layout for the two-way blocking data cache.
// The cache geometry is fixed here and every module derives its widths
// from these values. The way index is a single bit, so NUM_WAYS must stay 2.
package cache_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BE_W       = 4;
    localparam int BYTE_W     = DATA_W / BE_W;
    localparam int NUM_SETS   = 64;
    localparam int NUM_WAYS   = 2;
    localparam int LINE_WORDS = 4;
    localparam int TAG_W      = 22;
    localparam int SET_W      = 6;
    localparam int WORD_W     = 2;
    localparam int NLINE_W    = 28;
    localparam int TID_W      = 4;
    localparam int LINE_W     = 128;

    // Offsets below the word and below the line
    localparam int BYTE_OFF_W = ADDR_W - TAG_W - SET_W - WORD_W;
    localparam int LINE_OFF_W = ADDR_W - NLINE_W;

    localparam logic op_load  = 1'b0;
    localparam logic op_store = 1'b1;

    // One request address with two views.
    // Array indexing uses c, the miss request and refill use l
    typedef union packed {
        struct packed {
            logic [TAG_W-1:0]      tag;
            logic [SET_W-1:0]      set;
            logic [WORD_W-1:0]     word;
            logic [BYTE_OFF_W-1:0] byte_off;
        } c;
        struct packed {
            logic [NLINE_W-1:0]    nline;
            logic [LINE_OFF_W-1:0] line_off;
        } l;
    } req_addr_u;

    // Word 0 of a refill line sits in the low bits
    function automatic logic [DATA_W-1:0] line_word(
        input logic [LINE_W-1:0] line,
        input logic [WORD_W-1:0] word
    );
        return line[word*DATA_W +: DATA_W];
    endfunction

endpackage

/* cache_req_pipe.sv */
// Request payload of stages 1 and 2 and selection of the core response.
// Payload registers have no reset, the control module tracks validity.
// Stage 2 keeps only what a pending load miss needs.
module cache_req_pipe
    import cache_pkg::*;
(
    input  logic               clk_i,

    input  logic               core_req_op_i,
    input  logic [ADDR_W-1:0]  core_req_addr_i,
    input  logic [DATA_W-1:0]  core_req_wdata_i,
    input  logic [BE_W-1:0]    core_req_be_i,
    input  logic [TID_W-1:0]   core_req_tid_i,

    input  logic               st1_load_i,
    input  logic               st2_load_i,
    input  logic               rsp_from_refill_i,
    input  logic [DATA_W-1:0]  st1_rdata_i,
    input  logic [LINE_W-1:0]  refill_data_i,

    output req_addr_u          st1_addr_o,
    output logic [DATA_W-1:0]  st1_wdata_o,
    output logic [BE_W-1:0]    st1_be_o,
    output logic               st1_is_store_o,
    output logic               st1_is_load_o,
    output req_addr_u          st2_addr_o,
    output logic [NLINE_W-1:0] miss_req_nline_o,
    output logic [DATA_W-1:0]  core_rsp_rdata_o,
    output logic [TID_W-1:0]   core_rsp_tid_o
);

    logic              st1_op_q;
    req_addr_u         st1_addr_q;
    logic [DATA_W-1:0] st1_wdata_q;
    logic [BE_W-1:0]   st1_be_q;
    logic [TID_W-1:0]  st1_tid_q;
    req_addr_u         st2_addr_q;
    logic [TID_W-1:0]  st2_tid_q;

    always_ff @(posedge clk_i) begin
        if (st1_load_i) begin
            st1_op_q    <= core_req_op_i;
            st1_addr_q  <= core_req_addr_i;
            st1_wdata_q <= core_req_wdata_i;
            st1_be_q    <= core_req_be_i;
            st1_tid_q   <= core_req_tid_i;
        end
        if (st2_load_i) begin
            st2_addr_q <= st1_addr_q;
            st2_tid_q  <= st1_tid_q;
        end
    end

    assign st1_addr_o     = st1_addr_q;
    assign st1_wdata_o    = st1_wdata_q;
    assign st1_be_o       = st1_be_q;
    assign st1_is_store_o = (st1_op_q == op_store);
    assign st1_is_load_o  = (st1_op_q == op_load);

    assign st2_addr_o       = st2_addr_q;
    assign miss_req_nline_o = st2_addr_q.l.nline;

    // Refill answers the pending miss with the word it asked for
    assign core_rsp_rdata_o = rsp_from_refill_i ? line_word(refill_data_i, st2_addr_q.c.word)
                                                : st1_rdata_i;
    assign core_rsp_tid_o   = rsp_from_refill_i ? st2_tid_q : st1_tid_q;

endmodule

/* cache_top.sv */
// Blocking two-way data cache, write-through and no-write-allocate.
// Load hits answer one cycle after acceptance. A load miss sends one
// miss request and stalls the core until the full refill line arrives.
// All outputs toward memory are single-cycle strobes without handshake.
module cache_top
    import cache_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,

    input  logic               core_req_valid_i,
    output logic               core_req_ready_o,
    input  logic               core_req_op_i,
    input  logic [ADDR_W-1:0]  core_req_addr_i,
    input  logic [DATA_W-1:0]  core_req_wdata_i,
    input  logic [BE_W-1:0]    core_req_be_i,
    input  logic [TID_W-1:0]   core_req_tid_i,

    output logic               core_rsp_valid_o,
    output logic [DATA_W-1:0]  core_rsp_rdata_o,
    output logic [TID_W-1:0]   core_rsp_tid_o,

    output logic               mem_write_o,
    output logic [ADDR_W-1:0]  mem_write_addr_o,
    output logic [DATA_W-1:0]  mem_write_data_o,
    output logic [BE_W-1:0]    mem_write_be_o,

    output logic               miss_req_o,
    output logic [NLINE_W-1:0] miss_req_nline_o,

    input  logic               refill_valid_i,
    input  logic [LINE_W-1:0]  refill_data_i
);

    logic              array_read;
    logic              st1_load;
    logic              st2_load;
    logic              data_write;
    logic              refill_write;
    logic              rsp_from_refill;
    logic              st1_is_store;
    logic              st1_is_load;
    logic              dir_hit;
    logic              hit_way;
    logic              victim_way;
    logic [DATA_W-1:0] st1_rdata;
    req_addr_u         st0_addr;
    req_addr_u         st1_addr;
    req_addr_u         st2_addr;

    assign st0_addr         = core_req_addr_i;
    assign mem_write_addr_o = st1_addr;

    cache_ctrl_pe u_ctrl (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .core_req_valid_i  (core_req_valid_i),
        .st1_is_store_i    (st1_is_store),
        .st1_is_load_i     (st1_is_load),
        .dir_hit_i         (dir_hit),
        .refill_valid_i    (refill_valid_i),
        .core_req_ready_o  (core_req_ready_o),
        .array_read_o      (array_read),
        .st1_load_o        (st1_load),
        .st2_load_o        (st2_load),
        .data_write_o      (data_write),
        .refill_write_o    (refill_write),
        .rsp_valid_o       (core_rsp_valid_o),
        .rsp_from_refill_o (rsp_from_refill),
        .mem_write_o       (mem_write_o),
        .miss_req_o        (miss_req_o)
    );

    cache_req_pipe u_pipe (
        .clk_i             (clk_i),
        .core_req_op_i     (core_req_op_i),
        .core_req_addr_i   (core_req_addr_i),
        .core_req_wdata_i  (core_req_wdata_i),
        .core_req_be_i     (core_req_be_i),
        .core_req_tid_i    (core_req_tid_i),
        .st1_load_i        (st1_load),
        .st2_load_i        (st2_load),
        .rsp_from_refill_i (rsp_from_refill),
        .st1_rdata_i       (st1_rdata),
        .refill_data_i     (refill_data_i),
        .st1_addr_o        (st1_addr),
        .st1_wdata_o       (mem_write_data_o),
        .st1_be_o          (mem_write_be_o),
        .st1_is_store_o    (st1_is_store),
        .st1_is_load_o     (st1_is_load),
        .st2_addr_o        (st2_addr),
        .miss_req_nline_o  (miss_req_nline_o),
        .core_rsp_rdata_o  (core_rsp_rdata_o),
        .core_rsp_tid_o    (core_rsp_tid_o)
    );

    cache_dir u_dir (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .read_i        (array_read),
        .read_set_i    (st0_addr.c.set),
        .st1_tag_i     (st1_addr.c.tag),
        .refill_i      (refill_write),
        .refill_addr_i (st2_addr),
        .hit_o         (dir_hit),
        .hit_way_o     (hit_way),
        .victim_way_o  (victim_way)
    );

    cache_data u_data (
        .clk_i         (clk_i),
        .read_i        (array_read),
        .read_set_i    (st0_addr.c.set),
        .read_word_i   (st0_addr.c.word),
        .write_i       (data_write),
        .write_set_i   (st1_addr.c.set),
        .write_word_i  (st1_addr.c.word),
        .write_way_i   (hit_way),
        .write_data_i  (mem_write_data_o),
        .write_be_i    (mem_write_be_o),
        .refill_i      (refill_write),
        .refill_set_i  (st2_addr.c.set),
        .refill_way_i  (victim_way),
        .refill_data_i (refill_data_i),
        .rdata_o       (st1_rdata)
    );

endmodule

/* filelist.f */
cache_pkg.sv
cache_ctrl_pe.sv
cache_req_pipe.sv
cache_dir.sv
cache_data.sv
cache_top.sv
tb_checker.sv
tb_top.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing -f filelist.f --top-module tb_top -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tb_checker.sv */
// Scoreboard for the cache. Keeps its own two-way LRU directory and a
// shadow memory, and compares every strobe of the DUT against them.
// A store that hits also refreshes the LRU bit, as a load hit does.
// The shadow fill pattern must match the memory model in the testbench.
module tb_checker
    import cache_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               core_req_valid_i,
    input  logic               core_req_ready_i,
    input  logic               core_req_op_i,
    input  logic [ADDR_W-1:0]  core_req_addr_i,
    input  logic [DATA_W-1:0]  core_req_wdata_i,
    input  logic [BE_W-1:0]    core_req_be_i,
    input  logic [TID_W-1:0]   core_req_tid_i,
    input  logic               core_rsp_valid_i,
    input  logic [DATA_W-1:0]  core_rsp_rdata_i,
    input  logic [TID_W-1:0]   core_rsp_tid_i,
    input  logic               mem_write_i,
    input  logic [ADDR_W-1:0]  mem_write_addr_i,
    input  logic [DATA_W-1:0]  mem_write_data_i,
    input  logic [BE_W-1:0]    mem_write_be_i,
    input  logic               miss_req_i,
    input  logic [NLINE_W-1:0] miss_req_nline_i,
    input  logic               refill_valid_i,
    output int                 err_count_o,
    output logic               idle_o
);

    logic [TAG_W-1:0]  m_tag [NUM_WAYS][NUM_SETS];
    logic              m_valid [NUM_WAYS][NUM_SETS];
    logic              m_lru [NUM_SETS];
    logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] exp_data [$];
    logic [TID_W-1:0]  exp_tid [$];

    logic              write_due;
    logic [ADDR_W-1:0] w_addr;
    logic [DATA_W-1:0] w_data;
    logic [BE_W-1:0]   w_be;
    logic              hit_due;
    logic              miss_st1;
    logic              miss_st2;
    logic              miss_busy;
    logic [ADDR_W-1:0] miss_addr;
    int                errors = 0;

    assign err_count_o = errors;

    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5A5A_3C3C;
    endfunction

    function automatic logic [DATA_W-1:0] read_shadow(input logic [ADDR_W-1:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return fill_word(a);
    endfunction

    task automatic report(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    always @(posedge clk_i) begin
        logic              exp_ready;
        logic              exp_rsp;
        logic [ADDR_W-1:0] a;
        logic [5:0]        set;
        logic              hit;
        logic              way;
        logic              vic;
        logic [DATA_W-1:0] word;
        logic              new_write;
        logic              new_hit;
        logic              new_miss;

        new_write = 1'b0;
        new_hit   = 1'b0;
        new_miss  = 1'b0;
        if (!rst_ni) begin
            if ({core_rsp_valid_i, mem_write_i, miss_req_i} !== 3'b000) begin
                report("output strobe high during reset");
            end
            for (int s = 0; s < NUM_SETS; s++) begin
                m_valid[0][s] = 1'b0;
                m_valid[1][s] = 1'b0;
                m_lru[s]      = 1'b0;
            end
            write_due = 1'b0;
            hit_due   = 1'b0;
            miss_st1  = 1'b0;
            miss_st2  = 1'b0;
            miss_busy = 1'b0;
        end else begin
            exp_ready = !(write_due || miss_busy);
            if (core_req_ready_i !== exp_ready) begin
                report($sformatf("ready is %0b, expected %0b", core_req_ready_i, exp_ready));
            end

            // Write-through one cycle after the store was accepted
            if (mem_write_i !== write_due) begin
                report($sformatf("mem_write is %0b, expected %0b", mem_write_i, write_due));
            end else if (write_due) begin
                if (mem_write_addr_i !== w_addr || mem_write_data_i !== w_data ||
                    mem_write_be_i !== w_be) begin
                    report($sformatf("write %h/%h/%h, expected %h/%h/%h",
                        mem_write_addr_i, mem_write_data_i, mem_write_be_i,
                        w_addr, w_data, w_be));
                end
            end

            if (miss_req_i !== miss_st2) begin
                report($sformatf("miss_req is %0b, expected %0b", miss_req_i, miss_st2));
            end else if (miss_st2 && miss_req_nline_i !== miss_addr[31:4]) begin
                report($sformatf("miss nline %h, expected %h",
                    miss_req_nline_i, miss_addr[31:4]));
            end

            exp_rsp = hit_due || (miss_busy && refill_valid_i);
            if (core_rsp_valid_i !== exp_rsp) begin
                report($sformatf("rsp_valid is %0b, expected %0b", core_rsp_valid_i, exp_rsp));
            end else if (exp_rsp) begin
                if (core_rsp_rdata_i !== exp_data[0] || core_rsp_tid_i !== exp_tid[0]) begin
                    report($sformatf("rsp data %h tid %0d, expected %h tid %0d",
                        core_rsp_rdata_i, core_rsp_tid_i, exp_data[0], exp_tid[0]));
                end
                void'(exp_data.pop_front());
                void'(exp_tid.pop_front());
            end

            // Refill fills the LRU way, then the LRU bit flips
            if (refill_valid_i) begin
                if (!miss_busy) begin
                    $display("Refill at %0t arrived with no miss outstanding", $time);
                    errors++;
                end else begin
                    set = miss_addr[9:4];
                    vic = m_lru[set];
                    m_tag[vic][set]   = miss_addr[31:10];
                    m_valid[vic][set] = 1'b1;
                    m_lru[set]        = ~vic;
                    miss_busy         = 1'b0;
                end
            end

            if (core_req_valid_i && core_req_ready_i) begin
                a   = {core_req_addr_i[31:2], 2'b00};
                set = a[9:4];
                hit = 1'b0;
                way = 1'b0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                    if (m_valid[w][set] && m_tag[w][set] == a[31:10]) begin
                        hit = 1'b1;
                        way = 1'(w);
                    end
                end
                if (hit) begin
                    m_lru[set] = ~way;
                end
                if (core_req_op_i == op_load) begin
                    exp_data.push_back(read_shadow(a));
                    exp_tid.push_back(core_req_tid_i);
                    new_hit  = hit;
                    new_miss = !hit;
                    if (!hit) begin
                        miss_busy = 1'b1;
                        miss_addr = a;
                    end
                end else begin
                    word = read_shadow(a);
                    for (int b = 0; b < BE_W; b++) begin
                        if (core_req_be_i[b]) begin
                            word[b*8 +: 8] = core_req_wdata_i[b*8 +: 8];
                        end
                    end
                    shadow[a] = word;
                    new_write = 1'b1;
                    w_addr    = core_req_addr_i;
                    w_data    = core_req_wdata_i;
                    w_be      = core_req_be_i;
                end
            end

            write_due = new_write;
            hit_due   = new_hit;
            miss_st2  = miss_st1;
            miss_st1  = new_miss;
        end
        idle_o <= (exp_data.size() == 0) && !write_due && !miss_busy;
    end

endmodule

/* tb_top.sv */
// Testbench for the blocking two-way cache. Seeded random loads and stores
// over four tags and four sets, so hits, misses and evictions all occur.
// The memory model applies write-through strobes and answers each miss
// with a full line after 1 to 6 cycles.
module tb_top;
    import cache_pkg::*;

    localparam int NUM_REQ   = 400;
    localparam int WORST_CYC = 12;
    localparam int CLK_PER   = 4;
    localparam int RST_CYC   = 8;
    localparam int WATCHDOG  = NUM_REQ * WORST_CYC * CLK_PER + RST_CYC * CLK_PER;

    localparam logic [TAG_W-1:0] TAG_POOL [4] = '{22'h000A1, 22'h001F3, 22'h2C4E0, 22'h3D5F7};
    localparam logic [SET_W-1:0] SET_POOL [4] = '{6'd0, 6'd5, 6'd17, 6'd63};

    logic               clk_i = 1'b0;
    logic               rst_ni;
    logic               core_req_valid_i;
    logic               core_req_ready_o;
    logic               core_req_op_i;
    logic [ADDR_W-1:0]  core_req_addr_i;
    logic [DATA_W-1:0]  core_req_wdata_i;
    logic [BE_W-1:0]    core_req_be_i;
    logic [TID_W-1:0]   core_req_tid_i;
    logic               core_rsp_valid_o;
    logic [DATA_W-1:0]  core_rsp_rdata_o;
    logic [TID_W-1:0]   core_rsp_tid_o;
    logic               mem_write_o;
    logic [ADDR_W-1:0]  mem_write_addr_o;
    logic [DATA_W-1:0]  mem_write_data_o;
    logic [BE_W-1:0]    mem_write_be_o;
    logic               miss_req_o;
    logic [NLINE_W-1:0] miss_req_nline_o;
    logic               refill_valid_i;
    logic [LINE_W-1:0]  refill_data_i;
    int                 err_count;
    logic               chk_idle;

    int                 seed;
    logic [DATA_W-1:0]  mem [logic [ADDR_W-1:0]];

    always #(CLK_PER / 2) clk_i = ~clk_i;

    cache_top u_dut (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .core_req_valid_i (core_req_valid_i),
        .core_req_ready_o (core_req_ready_o),
        .core_req_op_i    (core_req_op_i),
        .core_req_addr_i  (core_req_addr_i),
        .core_req_wdata_i (core_req_wdata_i),
        .core_req_be_i    (core_req_be_i),
        .core_req_tid_i   (core_req_tid_i),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_rdata_o (core_rsp_rdata_o),
        .core_rsp_tid_o   (core_rsp_tid_o),
        .mem_write_o      (mem_write_o),
        .mem_write_addr_o (mem_write_addr_o),
        .mem_write_data_o (mem_write_data_o),
        .mem_write_be_o   (mem_write_be_o),
        .miss_req_o       (miss_req_o),
        .miss_req_nline_o (miss_req_nline_o),
        .refill_valid_i   (refill_valid_i),
        .refill_data_i    (refill_data_i)
    );

    tb_checker u_chk (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .core_req_valid_i (core_req_valid_i),
        .core_req_ready_i (core_req_ready_o),
        .core_req_op_i    (core_req_op_i),
        .core_req_addr_i  (core_req_addr_i),
        .core_req_wdata_i (core_req_wdata_i),
        .core_req_be_i    (core_req_be_i),
        .core_req_tid_i   (core_req_tid_i),
        .core_rsp_valid_i (core_rsp_valid_o),
        .core_rsp_rdata_i (core_rsp_rdata_o),
        .core_rsp_tid_i   (core_rsp_tid_o),
        .mem_write_i      (mem_write_o),
        .mem_write_addr_i (mem_write_addr_o),
        .mem_write_data_i (mem_write_data_o),
        .mem_write_be_i   (mem_write_be_o),
        .miss_req_i       (miss_req_o),
        .miss_req_nline_i (miss_req_nline_o),
        .refill_valid_i   (refill_valid_i),
        .err_count_o      (err_count),
        .idle_o           (chk_idle)
    );

    // Background contents, every address bit takes part
    function automatic logic [DATA_W-1:0] mem_read(input logic [ADDR_W-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ {a[15:0], a[31:16]} ^ 32'h5A5A_3C3C;
    endfunction

    always @(posedge clk_i) begin
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] word;

        if (rst_ni && mem_write_o) begin
            a    = {mem_write_addr_o[31:2], 2'b00};
            word = mem_read(a);
            for (int b = 0; b < BE_W; b++) begin
                if (mem_write_be_o[b]) begin
                    word[b*8 +: 8] = mem_write_data_o[b*8 +: 8];
                end
            end
            mem[a] = word;
        end
    end

    // Refill responder
    always begin
        logic [NLINE_W-1:0] nline;
        logic [31:0]        rv;
        int                 delay;

        @(posedge clk_i);
        if (rst_ni && miss_req_o) begin
            nline = miss_req_nline_o;
            rv    = $random(seed);
            delay = 1 + int'(rv[7:0]) % 6;
            repeat (delay - 1) @(posedge clk_i);
            #1;
            for (int i = 0; i < LINE_WORDS; i++) begin
                refill_data_i[i*DATA_W +: DATA_W] = mem_read({nline, 2'(i), 2'b00});
            end
            refill_valid_i = 1'b1;
            @(posedge clk_i);
            #1;
            refill_valid_i = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [31:0] rv;

        seed             = 1949;
        rst_ni           = 1'b0;
        core_req_valid_i = 1'b0;
        core_req_op_i    = op_load;
        core_req_addr_i  = '0;
        core_req_wdata_i = '0;
        core_req_be_i    = '0;
        core_req_tid_i   = '0;
        refill_valid_i   = 1'b0;
        refill_data_i    = '0;
        repeat (RST_CYC) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        for (int n = 0; n < NUM_REQ; n++) begin
            rv = $random(seed);
            if (rv[3:0] == 4'd0) begin
                @(posedge clk_i);
                #1;
            end
            rv = $random(seed);
            core_req_op_i    = rv[0] ? op_store : op_load;
            core_req_addr_i  = {TAG_POOL[rv[2:1]], SET_POOL[rv[4:3]], rv[6:5], 2'b00};
            core_req_be_i    = rv[10:7];
            core_req_wdata_i = $random(seed);
            core_req_valid_i = 1'b1;
            @(posedge clk_i);
            while (!core_req_ready_o) @(posedge clk_i);
            #1;
            core_req_valid_i = 1'b0;
            core_req_tid_i   = core_req_tid_i + 1'b1;
        end

        @(posedge clk_i);
        while (!chk_idle) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        $display("Run finished: %0d requests, %0d errors", NUM_REQ, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
